//--- src/mcu_io_pkg.sv
/*
 * mcu i/o register page definitions
 * bus widths, payload types, register offsets and reset values
 */
package mcu_io_pkg;

	localparam int ADDR_W    = 32; // cpu bus address
	localparam int DATA_W    = 32; // cpu bus data
	localparam int SLOT_ID_W = 16;
	localparam int ERR_W     = 3;

	typedef logic [DATA_W-1:0]    word_t;
	typedef logic [SLOT_ID_W-1:0] slot_id_t;
	typedef logic [ERR_W-1:0]     err_t; // zero means ok

	// upper half of the address selects the page
	localparam logic [15:0] IO_PAGE = 16'hFFFF;

	// target dataslot command block
	localparam logic [15:0] OFS_SLOT_ID     = 16'h0080;
	localparam logic [15:0] OFS_BRIDGE_ADDR = 16'h0084;
	localparam logic [15:0] OFS_LENGTH      = 16'h0088;
	localparam logic [15:0] OFS_SLOT_OFFSET = 16'h008C;
	localparam logic [15:0] OFS_CMD         = 16'h0090; // wr strobes, rd status

	localparam logic [15:0] OFS_TICK_PERIOD   = 16'h0098;
	localparam logic [15:0] OFS_RESET_OUT     = 16'h00A4;
	localparam logic [15:0] OFS_UPDATE_STATUS = 16'h00B0; // clear on read
	localparam logic [15:0] OFS_UPDATE_ID     = 16'h00B4;
	localparam logic [15:0] OFS_UPDATE_SIZE   = 16'h00B8;
	localparam logic [15:0] OFS_TIMER         = 16'h00C8;

	typedef enum logic [3:0] {
		REG_NONE,          // unmapped or off page
		REG_SLOT_ID,
		REG_BRIDGE_ADDR,
		REG_LENGTH,
		REG_SLOT_OFFSET,
		REG_CMD,
		REG_TICK_PERIOD,
		REG_RESET_OUT,
		REG_UPDATE_STATUS,
		REG_UPDATE_ID,
		REG_UPDATE_SIZE,
		REG_TIMER
	} reg_sel_t;

	// cycles per ms tick minus one, 25 MHz clock
	localparam word_t TICK_PERIOD_RESET = 32'd24999;

endpackage

//--- src/mcu_bus_decode.sv
/*
 * cpu bus decoder for the mcu i/o page
 * req/ack handshake, register select, read merge, core reset register
 */
`timescale 1ns/1ps

module mcu_bus_decode (
	input  logic                          clk_sys,
	input  logic                          reset_n,

	// cpu side
	input  logic                          cpu_req,
	input  logic [mcu_io_pkg::ADDR_W-1:0] cpu_addr,
	input  logic                          cpu_wr,
	input  mcu_io_pkg::word_t             cpu_wdata,
	output logic                          cpu_ack,
	output mcu_io_pkg::word_t             cpu_rdata,

	// peripheral side
	input  mcu_io_pkg::word_t             cmd_rdata,
	input  mcu_io_pkg::word_t             update_rdata,
	input  mcu_io_pkg::word_t             timer_rdata,
	output mcu_io_pkg::reg_sel_t          reg_sel,
	output logic                          reg_wr,
	output logic                          reg_rd,
	output mcu_io_pkg::word_t             reg_wdata,

	output logic                          reset_out // core reset, software controlled
);

	logic              take;        // request seen, not yet acked
	logic              on_page;
	logic [15:0]       offset;
	mcu_io_pkg::word_t reset_rdata;
	mcu_io_pkg::word_t merged;

	// held request only acked once, ack cycle blocks the retake
	assign take = cpu_req & ~cpu_ack;

	assign reg_wr    = take & cpu_wr;  // acted on at the ack edge
	assign reg_rd    = take & ~cpu_wr;
	assign reg_wdata = cpu_wdata;

	assign on_page = (cpu_addr[mcu_io_pkg::ADDR_W-1:16] == mcu_io_pkg::IO_PAGE);
	assign offset  = cpu_addr[15:0];

	always_comb begin
		reg_sel = mcu_io_pkg::REG_NONE;
		if (on_page) begin
			case (offset)
				mcu_io_pkg::OFS_SLOT_ID:       reg_sel = mcu_io_pkg::REG_SLOT_ID;
				mcu_io_pkg::OFS_BRIDGE_ADDR:   reg_sel = mcu_io_pkg::REG_BRIDGE_ADDR;
				mcu_io_pkg::OFS_LENGTH:        reg_sel = mcu_io_pkg::REG_LENGTH;
				mcu_io_pkg::OFS_SLOT_OFFSET:   reg_sel = mcu_io_pkg::REG_SLOT_OFFSET;
				mcu_io_pkg::OFS_CMD:           reg_sel = mcu_io_pkg::REG_CMD;
				mcu_io_pkg::OFS_TICK_PERIOD:   reg_sel = mcu_io_pkg::REG_TICK_PERIOD;
				mcu_io_pkg::OFS_RESET_OUT:     reg_sel = mcu_io_pkg::REG_RESET_OUT;
				mcu_io_pkg::OFS_UPDATE_STATUS: reg_sel = mcu_io_pkg::REG_UPDATE_STATUS;
				mcu_io_pkg::OFS_UPDATE_ID:     reg_sel = mcu_io_pkg::REG_UPDATE_ID;
				mcu_io_pkg::OFS_UPDATE_SIZE:   reg_sel = mcu_io_pkg::REG_UPDATE_SIZE;
				mcu_io_pkg::OFS_TIMER:         reg_sel = mcu_io_pkg::REG_TIMER;
				default:                       reg_sel = mcu_io_pkg::REG_NONE;
			endcase
		end
	end

	// own register joins the merge like any peripheral
	assign reset_rdata = (reg_sel == mcu_io_pkg::REG_RESET_OUT) ?
		{{(mcu_io_pkg::DATA_W-1){1'b0}}, reset_out} : '0;

	// each source is zero unless selected, so a plain OR
	assign merged = cmd_rdata | update_rdata | timer_rdata | reset_rdata;

	// one clock latency, single pulse per request
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			cpu_ack <= 1'b0;
		end else begin
			cpu_ack <= take;
		end
	end

	// read word lands in the ack cycle
	always_ff @(posedge clk_sys) begin
		cpu_rdata <= reg_rd ? merged : '0;
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			reset_out <= 1'b0;
		end else if (reg_wr && reg_sel == mcu_io_pkg::REG_RESET_OUT) begin
			reset_out <= reg_wdata[0]; // bit 0 only
		end
	end

endmodule

//--- src/target_command_regs.sv
/*
 * target dataslot command registers
 * read/write parameters, one-cycle command strobes, status word
 */
`timescale 1ns/1ps

module target_command_regs (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  mcu_io_pkg::reg_sel_t reg_sel,
	input  logic                 reg_wr,
	input  mcu_io_pkg::word_t    reg_wdata,

	input  logic                 target_dataslot_ack,  // high while command runs
	input  logic                 target_dataslot_done, // high until next command
	input  mcu_io_pkg::err_t     target_dataslot_err,

	output mcu_io_pkg::word_t    rdata,
	output logic                 target_dataslot_read,
	output logic                 target_dataslot_write,
	output mcu_io_pkg::slot_id_t target_dataslot_id,
	output mcu_io_pkg::word_t    target_dataslot_bridgeaddr,
	output mcu_io_pkg::word_t    target_dataslot_length,
	output mcu_io_pkg::word_t    target_dataslot_slotoffset
);

	logic cmd_wr;

	assign cmd_wr = reg_wr && reg_sel == mcu_io_pkg::REG_CMD;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_id         <= '0;
			target_dataslot_bridgeaddr <= '0;
			target_dataslot_length     <= '0;
			target_dataslot_slotoffset <= '0;
			target_dataslot_read       <= 1'b0;
			target_dataslot_write      <= 1'b0;
		end else begin
			// strobes high for the cycle following the write
			target_dataslot_read  <= cmd_wr & reg_wdata[0];
			target_dataslot_write <= cmd_wr & reg_wdata[1];
			if (reg_wr) begin
				case (reg_sel)
					mcu_io_pkg::REG_SLOT_ID:     target_dataslot_id <= reg_wdata[15:0]; // truncated
					mcu_io_pkg::REG_BRIDGE_ADDR: target_dataslot_bridgeaddr <= reg_wdata;
					mcu_io_pkg::REG_LENGTH:      target_dataslot_length <= reg_wdata;
					mcu_io_pkg::REG_SLOT_OFFSET: target_dataslot_slotoffset <= reg_wdata;
					default: ;
				endcase
			end
		end
	end

	// readback, status taken straight off the inputs
	always_comb begin
		case (reg_sel)
			mcu_io_pkg::REG_SLOT_ID:     rdata = {16'h0000, target_dataslot_id};
			mcu_io_pkg::REG_BRIDGE_ADDR: rdata = target_dataslot_bridgeaddr;
			mcu_io_pkg::REG_LENGTH:      rdata = target_dataslot_length;
			mcu_io_pkg::REG_SLOT_OFFSET: rdata = target_dataslot_slotoffset;
			mcu_io_pkg::REG_CMD: begin
				// ack bit 4, done bit 3, err 2:0
				rdata = {27'd0, target_dataslot_ack, target_dataslot_done, target_dataslot_err};
			end
			default:                     rdata = '0;
		endcase
	end

endmodule

//--- src/dataslot_update_capture.sv
/*
 * host dataslot update capture
 * latches id and size, pending flag drives irq, clear on status read
 */
`timescale 1ns/1ps

module dataslot_update_capture (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  mcu_io_pkg::reg_sel_t reg_sel,
	input  logic                 reg_rd,
	input  logic                 dataslot_update,      // one cycle pulse
	input  mcu_io_pkg::slot_id_t dataslot_update_id,
	input  mcu_io_pkg::word_t    dataslot_update_size,
	output mcu_io_pkg::word_t    rdata,
	output logic                 irq
);

	mcu_io_pkg::slot_id_t upd_id;
	mcu_io_pkg::word_t    upd_size;
	logic                 pending;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			upd_id   <= '0;
			upd_size <= '0;
			pending  <= 1'b0;
		end else begin
			if (dataslot_update) begin
				upd_id   <= dataslot_update_id;
				upd_size <= dataslot_update_size;
				pending  <= 1'b1; // new update beats a clearing read
			end else if (reg_rd && reg_sel == mcu_io_pkg::REG_UPDATE_STATUS) begin
				pending  <= 1'b0;
			end
		end
	end

	assign irq = pending; // level, not a pulse

	always_comb begin
		case (reg_sel)
			mcu_io_pkg::REG_UPDATE_STATUS: rdata = {31'd0, pending}; // pre-clear value
			mcu_io_pkg::REG_UPDATE_ID:     rdata = {16'h0000, upd_id};
			mcu_io_pkg::REG_UPDATE_SIZE:   rdata = upd_size;
			default:                       rdata = '0;
		endcase
	end

endmodule

//--- src/millisecond_timer.sv
/*
 * millisecond timer
 * programmable tick divider feeding a 32 bit counter, clear on write
 */
`timescale 1ns/1ps

module millisecond_timer (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  mcu_io_pkg::reg_sel_t reg_sel,
	input  logic                 reg_wr,
	input  mcu_io_pkg::word_t    reg_wdata,
	output mcu_io_pkg::word_t    rdata
);

	mcu_io_pkg::word_t tick_period; // wrap value, period+1 cycles per tick
	mcu_io_pkg::word_t divider;
	mcu_io_pkg::word_t ms_count;
	logic              clear;

	assign clear = reg_wr && reg_sel == mcu_io_pkg::REG_TIMER && reg_wdata[0];

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick_period <= mcu_io_pkg::TICK_PERIOD_RESET;
		end else if (reg_wr && reg_sel == mcu_io_pkg::REG_TICK_PERIOD) begin
			tick_period <= reg_wdata;
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			divider  <= '0;
			ms_count <= '0;
		end else if (clear) begin
			divider  <= '0;
			ms_count <= '0;
		end else if (divider >= tick_period) begin
			// >= so a shrunk period still wraps right away
			divider  <= '0;
			ms_count <= ms_count + 32'd1;
		end else begin
			divider  <= divider + 32'd1;
		end
	end

	always_comb begin
		case (reg_sel)
			mcu_io_pkg::REG_TICK_PERIOD: rdata = tick_period;
			mcu_io_pkg::REG_TIMER:       rdata = ms_count;
			default:                     rdata = '0;
		endcase
	end

endmodule

//--- src/mcu_io_top.sv
/*
 * mcu i/o peripheral slave
 * bus decoder plus command, update capture and timer blocks
 */
`timescale 1ns/1ps

module mcu_io_top (
	input  logic                          clk_sys,
	input  logic                          reset_n,

	// cpu bus
	input  logic                          cpu_req,
	input  logic [mcu_io_pkg::ADDR_W-1:0] cpu_addr,
	input  mcu_io_pkg::word_t             cpu_wdata,
	input  logic                          cpu_wr,
	output logic                          cpu_ack,
	output mcu_io_pkg::word_t             cpu_rdata,

	// target dataslot commands
	output logic                          target_dataslot_read,
	output logic                          target_dataslot_write,
	input  logic                          target_dataslot_ack,
	input  logic                          target_dataslot_done,
	input  mcu_io_pkg::err_t              target_dataslot_err,
	output mcu_io_pkg::slot_id_t          target_dataslot_id,
	output mcu_io_pkg::word_t             target_dataslot_bridgeaddr,
	output mcu_io_pkg::word_t             target_dataslot_length,
	output mcu_io_pkg::word_t             target_dataslot_slotoffset,

	// host updates
	input  logic                          dataslot_update,
	input  mcu_io_pkg::slot_id_t          dataslot_update_id,
	input  mcu_io_pkg::word_t             dataslot_update_size,
	output logic                          irq,

	output logic                          reset_out
);

	mcu_io_pkg::reg_sel_t reg_sel;
	logic                 reg_wr;
	logic                 reg_rd;
	mcu_io_pkg::word_t    reg_wdata;
	mcu_io_pkg::word_t    cmd_rdata;
	mcu_io_pkg::word_t    update_rdata;
	mcu_io_pkg::word_t    timer_rdata;

	mcu_bus_decode u_decode (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.cpu_req      (cpu_req),
		.cpu_addr     (cpu_addr),
		.cpu_wr       (cpu_wr),
		.cpu_wdata    (cpu_wdata),
		.cpu_ack      (cpu_ack),
		.cpu_rdata    (cpu_rdata),
		.cmd_rdata    (cmd_rdata),
		.update_rdata (update_rdata),
		.timer_rdata  (timer_rdata),
		.reg_sel      (reg_sel),
		.reg_wr       (reg_wr),
		.reg_rd       (reg_rd),
		.reg_wdata    (reg_wdata),
		.reset_out    (reset_out)
	);

	target_command_regs u_cmd (
		.clk_sys                    (clk_sys),
		.reset_n                    (reset_n),
		.reg_sel                    (reg_sel),
		.reg_wr                     (reg_wr),
		.reg_wdata                  (reg_wdata),
		.target_dataslot_ack        (target_dataslot_ack),
		.target_dataslot_done       (target_dataslot_done),
		.target_dataslot_err        (target_dataslot_err),
		.rdata                      (cmd_rdata),
		.target_dataslot_read       (target_dataslot_read),
		.target_dataslot_write      (target_dataslot_write),
		.target_dataslot_id         (target_dataslot_id),
		.target_dataslot_bridgeaddr (target_dataslot_bridgeaddr),
		.target_dataslot_length     (target_dataslot_length),
		.target_dataslot_slotoffset (target_dataslot_slotoffset)
	);

	dataslot_update_capture u_update (
		.clk_sys              (clk_sys),
		.reset_n              (reset_n),
		.reg_sel              (reg_sel),
		.reg_rd               (reg_rd),
		.dataslot_update      (dataslot_update),
		.dataslot_update_id   (dataslot_update_id),
		.dataslot_update_size (dataslot_update_size),
		.rdata                (update_rdata),
		.irq                  (irq)
	);

	millisecond_timer u_timer (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.reg_sel   (reg_sel),
		.reg_wr    (reg_wr),
		.reg_wdata (reg_wdata),
		.rdata     (timer_rdata)
	);

endmodule

//--- test/mcu_io_tb.sv
/*
 * self-checking testbench for mcu_io_top
 * table of bus reads and writes, update capture and timer sequences
 */
`timescale 1ns/1ps

module mcu_io_tb;

	localparam int          CLK_PERIOD   = 40;
	localparam int          RESET_CYCLES = 16;
	localparam int          CYCLES_EACH  = 40;  // watchdog budget per table entry
	localparam int          MARGIN       = 400;
	localparam int          ACK_LIMIT    = 4;
	localparam int          TIMER_PERIOD = 9;   // P
	localparam int          TIMER_TICKS  = 20;  // K
	localparam int          TIMER_WAIT   = (TIMER_PERIOD + 1) * TIMER_TICKS;
	localparam logic [31:0] RAND_SEED    = 32'hfeb5_1d0b;

	typedef logic [mcu_io_pkg::ADDR_W-1:0] addr_t;
	typedef enum logic [1:0] {OP_WR, OP_RD, OP_CMD} op_t;

	typedef struct {
		op_t               op;
		addr_t             addr;
		mcu_io_pkg::word_t wdata;
		mcu_io_pkg::word_t exp_val; // read value or output value after a write
		logic [4:0]        st;      // ack, done, err driven on the target inputs
	} entry_t;

	logic                    clk_sys = 1'b0;
	logic                    reset_n;
	logic                    cpu_req;
	addr_t                   cpu_addr;
	mcu_io_pkg::word_t       cpu_wdata;
	logic                    cpu_wr;
	logic                    cpu_ack;
	mcu_io_pkg::word_t       cpu_rdata;
	logic                    target_dataslot_read;
	logic                    target_dataslot_write;
	logic                    target_dataslot_ack;
	logic                    target_dataslot_done;
	mcu_io_pkg::err_t        target_dataslot_err;
	mcu_io_pkg::slot_id_t    target_dataslot_id;
	mcu_io_pkg::word_t       target_dataslot_bridgeaddr;
	mcu_io_pkg::word_t       target_dataslot_length;
	mcu_io_pkg::word_t       target_dataslot_slotoffset;
	logic                    dataslot_update;
	mcu_io_pkg::slot_id_t    dataslot_update_id;
	mcu_io_pkg::word_t       dataslot_update_size;
	logic                    irq;
	logic                    reset_out;

	entry_t     table_q[$];
	logic       table_ready = 1'b0;
	logic [1:0] early_strobes; // {write, read} seen before cpu_ack
	logic [1:0] ack_strobes;   // {write, read} in the cpu_ack cycle

	mcu_io_top UUT (
		.clk_sys                    (clk_sys),
		.reset_n                    (reset_n),
		.cpu_req                    (cpu_req),
		.cpu_addr                   (cpu_addr),
		.cpu_wdata                  (cpu_wdata),
		.cpu_wr                     (cpu_wr),
		.cpu_ack                    (cpu_ack),
		.cpu_rdata                  (cpu_rdata),
		.target_dataslot_read       (target_dataslot_read),
		.target_dataslot_write      (target_dataslot_write),
		.target_dataslot_ack        (target_dataslot_ack),
		.target_dataslot_done       (target_dataslot_done),
		.target_dataslot_err        (target_dataslot_err),
		.target_dataslot_id         (target_dataslot_id),
		.target_dataslot_bridgeaddr (target_dataslot_bridgeaddr),
		.target_dataslot_length     (target_dataslot_length),
		.target_dataslot_slotoffset (target_dataslot_slotoffset),
		.dataslot_update            (dataslot_update),
		.dataslot_update_id         (dataslot_update_id),
		.dataslot_update_size       (dataslot_update_size),
		.irq                        (irq),
		.reset_out                  (reset_out)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys; // 25 MHz

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_word(input mcu_io_pkg::word_t got, input mcu_io_pkg::word_t exp,
			input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_slot_id(input mcu_io_pkg::slot_id_t got,
			input mcu_io_pkg::slot_id_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// counter value with slack for handshake alignment
	task automatic check_range(input mcu_io_pkg::word_t got, input mcu_io_pkg::word_t lo,
			input mcu_io_pkg::word_t hi, input string what);
		if (got < lo || got > hi) begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d to %0d",
				$time, what, got, lo, hi);
			abort_run();
		end
	endtask

	function automatic addr_t page_addr(input logic [15:0] ofs);
		return {mcu_io_pkg::IO_PAGE, ofs};
	endfunction

	// ack bit 4, done bit 3, err in 2:0
	function automatic mcu_io_pkg::word_t status_word(input logic [4:0] st);
		mcu_io_pkg::word_t w;
		w      = '0;
		w[4]   = st[4];
		w[3]   = st[3];
		w[2:0] = st[2:0];
		return w;
	endfunction

	// one request that returns on the edge dropping cpu_req
	task automatic bus_cycle(input addr_t addr, input logic wr, input mcu_io_pkg::word_t wdata,
			output mcu_io_pkg::word_t rdata);
		int   waited;
		logic acked;
		waited        = 0;
		acked         = 1'b0;
		early_strobes = 2'b00;
		@(posedge clk_sys);
		cpu_req   <= 1'b1;
		cpu_addr  <= addr;
		cpu_wr    <= wr;
		cpu_wdata <= wdata;
		while (!acked) begin
			@(negedge clk_sys); // outputs settled
			if (cpu_ack) begin
				acked = 1'b1;
			end else begin
				early_strobes = early_strobes | {target_dataslot_write, target_dataslot_read};
				waited++;
				if (waited >= ACK_LIMIT) begin
					$display("No cpu_ack within %0d cycles of a request to %h", ACK_LIMIT, addr);
					abort_run();
				end
			end
		end
		rdata       = cpu_rdata;
		ack_strobes = {target_dataslot_write, target_dataslot_read};
		@(posedge clk_sys);
		cpu_req <= 1'b0;
		cpu_wr  <= 1'b0;
	endtask

	task automatic bus_write(input addr_t addr, input mcu_io_pkg::word_t wdata);
		mcu_io_pkg::word_t unused_rd;
		bus_cycle(addr, 1'b1, wdata, unused_rd);
	endtask

	task automatic bus_read(input addr_t addr, output mcu_io_pkg::word_t rdata);
		bus_cycle(addr, 1'b0, '0, rdata);
	endtask

	task automatic add_entry(input op_t op, input addr_t addr, input mcu_io_pkg::word_t wdata,
			input mcu_io_pkg::word_t exp_val, input logic [4:0] st);
		entry_t e;
		e.op      = op;
		e.addr    = addr;
		e.wdata   = wdata;
		e.exp_val = exp_val;
		e.st      = st;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		logic [15:0]       cmd_ofs[4];
		logic [4:0]        st_list[5];
		mcu_io_pkg::word_t rnd;
		mcu_io_pkg::word_t exp;
		cmd_ofs = '{mcu_io_pkg::OFS_SLOT_ID, mcu_io_pkg::OFS_BRIDGE_ADDR,
			mcu_io_pkg::OFS_LENGTH, mcu_io_pkg::OFS_SLOT_OFFSET};
		st_list = '{5'b10000, 5'b01000, 5'b00101, 5'b11111, 5'b00000};
		// reset values
		foreach (cmd_ofs[i]) add_entry(OP_RD, page_addr(cmd_ofs[i]), '0, '0, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_CMD), '0, '0, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_TICK_PERIOD), '0,
			mcu_io_pkg::TICK_PERIOD_RESET, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_RESET_OUT), '0, '0, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_UPDATE_STATUS), '0, '0, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_UPDATE_ID), '0, '0, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_UPDATE_SIZE), '0, '0, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_TIMER), '0, '0, 5'b0);
		// holes in the page
		add_entry(OP_RD, page_addr(16'h0094), '0, '0, 5'b0);
		add_entry(OP_RD, page_addr(16'h0000), '0, '0, 5'b0);
		add_entry(OP_RD, page_addr(16'h00FC), '0, '0, 5'b0);
		// command parameters where the id keeps 16 bits
		foreach (cmd_ofs[i]) begin
			rnd = $urandom();
			exp = (cmd_ofs[i] == mcu_io_pkg::OFS_SLOT_ID) ? {16'h0000, rnd[15:0]} : rnd;
			add_entry(OP_WR, page_addr(cmd_ofs[i]), rnd, exp, 5'b0);
			add_entry(OP_RD, page_addr(cmd_ofs[i]), '0, exp, 5'b0);
		end
		// other pages alias the offsets of the registers just written
		add_entry(OP_RD, 32'h0000_0080, '0, '0, 5'b0);
		add_entry(OP_RD, 32'hFFFE_0084, '0, '0, 5'b0);
		// strobes with bit 0 for read and bit 1 for write
		for (int c = 0; c < 4; c++) begin
			add_entry(OP_CMD, page_addr(mcu_io_pkg::OFS_CMD), mcu_io_pkg::word_t'(c),
				mcu_io_pkg::word_t'(c), 5'b0);
		end
		foreach (st_list[i]) begin
			add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_CMD), '0, status_word(st_list[i]),
				st_list[i]);
		end
		add_entry(OP_WR, page_addr(mcu_io_pkg::OFS_RESET_OUT), 32'd1, 32'd1, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_RESET_OUT), '0, 32'd1, 5'b0);
		add_entry(OP_WR, page_addr(mcu_io_pkg::OFS_RESET_OUT), 32'd0, 32'd0, 5'b0);
		add_entry(OP_RD, page_addr(mcu_io_pkg::OFS_RESET_OUT), '0, 32'd0, 5'b0);
	endtask

	// registered outputs that follow a write
	task automatic check_write_outputs(input addr_t addr, input mcu_io_pkg::word_t exp,
			input string what);
		@(negedge clk_sys);
		case (addr[15:0])
			mcu_io_pkg::OFS_SLOT_ID:     check_slot_id(target_dataslot_id, exp[15:0], what);
			mcu_io_pkg::OFS_BRIDGE_ADDR: check_word(target_dataslot_bridgeaddr, exp, what);
			mcu_io_pkg::OFS_LENGTH:      check_word(target_dataslot_length, exp, what);
			mcu_io_pkg::OFS_SLOT_OFFSET: check_word(target_dataslot_slotoffset, exp, what);
			mcu_io_pkg::OFS_RESET_OUT:   check_bit(reset_out, exp[0], what);
			default: ;
		endcase
	endtask

	task automatic apply_entry(input int idx, input entry_t e);
		mcu_io_pkg::word_t rd;
		string             what;
		what = $sformatf("entry %0d at %h", idx, e.addr);
		@(posedge clk_sys);
		target_dataslot_ack  <= e.st[4];
		target_dataslot_done <= e.st[3];
		target_dataslot_err  <= e.st[2:0];
		case (e.op)
			OP_WR: begin
				bus_write(e.addr, e.wdata);
				check_write_outputs(e.addr, e.exp_val, what);
			end
			OP_RD: begin
				bus_read(e.addr, rd);
				check_word(rd, e.exp_val, what);
			end
			OP_CMD: begin
				bus_write(e.addr, e.wdata);
				check_bit(early_strobes[0], 1'b0, {what, " read strobe before ack"});
				check_bit(early_strobes[1], 1'b0, {what, " write strobe before ack"});
				check_bit(ack_strobes[0], e.exp_val[0], {what, " read strobe"});
				check_bit(ack_strobes[1], e.exp_val[1], {what, " write strobe"});
				@(negedge clk_sys); // strobes last a single cycle
				check_bit(target_dataslot_read, 1'b0, {what, " read strobe after ack"});
				check_bit(target_dataslot_write, 1'b0, {what, " write strobe after ack"});
			end
			default: ;
		endcase
	endtask

	task automatic run_update_test();
		mcu_io_pkg::word_t    rnd;
		mcu_io_pkg::slot_id_t id;
		mcu_io_pkg::word_t    size;
		mcu_io_pkg::word_t    rd;
		rnd  = $urandom();
		id   = rnd[15:0];
		size = $urandom();
		@(posedge clk_sys);
		dataslot_update      <= 1'b1;
		dataslot_update_id   <= id;
		dataslot_update_size <= size;
		@(negedge clk_sys);
		check_bit(irq, 1'b0, "irq before the update edge");
		@(posedge clk_sys);
		dataslot_update <= 1'b0;
		@(negedge clk_sys);
		check_bit(irq, 1'b1, "irq after dataslot_update");
		bus_read(page_addr(mcu_io_pkg::OFS_UPDATE_ID), rd);
		check_slot_id(rd[15:0], id, "update id");
		check_word(rd, {16'h0000, id}, "update id word");
		bus_read(page_addr(mcu_io_pkg::OFS_UPDATE_SIZE), rd);
		check_word(rd, size, "update size");
		bus_read(page_addr(mcu_io_pkg::OFS_UPDATE_STATUS), rd);
		check_word(rd, 32'd1, "first update status");
		@(negedge clk_sys);
		check_bit(irq, 1'b0, "irq after status read"); // cleared by the read
		bus_read(page_addr(mcu_io_pkg::OFS_UPDATE_STATUS), rd);
		check_word(rd, 32'd0, "second update status");
	endtask

	task automatic run_timer_test();
		mcu_io_pkg::word_t rd;
		bus_write(page_addr(mcu_io_pkg::OFS_TICK_PERIOD), mcu_io_pkg::word_t'(TIMER_PERIOD));
		bus_read(page_addr(mcu_io_pkg::OFS_TICK_PERIOD), rd);
		check_word(rd, mcu_io_pkg::word_t'(TIMER_PERIOD), "tick period");
		bus_write(page_addr(mcu_io_pkg::OFS_TIMER), 32'd1); // clear
		bus_read(page_addr(mcu_io_pkg::OFS_TIMER), rd);
		check_word(rd, 32'd0, "millisecond counter after clear"); // no tick yet
		repeat (TIMER_WAIT) @(posedge clk_sys);
		bus_read(page_addr(mcu_io_pkg::OFS_TIMER), rd);
		check_range(rd, mcu_io_pkg::word_t'(TIMER_TICKS - 1),
			mcu_io_pkg::word_t'(TIMER_TICKS + 1), "millisecond counter");
	endtask

	// budget from the table length, timer wait and a margin
	initial begin
		wait (table_ready);
		#((RESET_CYCLES + table_q.size() * CYCLES_EACH + TIMER_WAIT + MARGIN) * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		abort_run();
	end

	initial begin
		reset_n              = 1'b0;
		cpu_req              = 1'b0;
		cpu_addr             = '0;
		cpu_wdata            = '0;
		cpu_wr               = 1'b0;
		target_dataslot_ack  = 1'b0;
		target_dataslot_done = 1'b0;
		target_dataslot_err  = '0;
		dataslot_update      = 1'b0;
		dataslot_update_id   = '0;
		dataslot_update_size = '0;
		void'($urandom(RAND_SEED)); // one seed for the whole run
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(negedge clk_sys);
		check_bit(cpu_ack, 1'b0, "cpu_ack after reset");
		check_bit(target_dataslot_read, 1'b0, "read strobe after reset");
		check_bit(target_dataslot_write, 1'b0, "write strobe after reset");
		check_bit(irq, 1'b0, "irq after reset");
		check_bit(reset_out, 1'b0, "reset_out after reset");
		for (int i = 0; i < table_q.size(); i++) begin
			apply_entry(i, table_q[i]);
		end
		run_update_test();
		run_timer_test();
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- mcu_io_top.f
src/mcu_io_pkg.sv
src/mcu_bus_decode.sv
src/target_command_regs.sv
src/dataslot_update_capture.sv
src/millisecond_timer.sv
src/mcu_io_top.sv
test/mcu_io_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = mcu_io_tb
FILELIST  = mcu_io_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
